// File: hdl/csr_pkg.sv
package csr_pkg;

    typedef logic [31:0] word_t;
    typedef logic [13:0] csr_num_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;
    typedef logic [1:0]  plv_t;

    ////////////////////
    // csr numbers
    ////////////////////
    localparam csr_num_t CSR_CRMD   = 14'h0;
    localparam csr_num_t CSR_PRMD   = 14'h1;
    localparam csr_num_t CSR_ECFG   = 14'h4;
    localparam csr_num_t CSR_ESTAT  = 14'h5;
    localparam csr_num_t CSR_ERA    = 14'h6;
    localparam csr_num_t CSR_BADV   = 14'h7;
    localparam csr_num_t CSR_EENTRY = 14'hc;
    localparam csr_num_t CSR_SAVE0  = 14'h30;
    localparam csr_num_t CSR_SAVE1  = 14'h31;
    localparam csr_num_t CSR_SAVE2  = 14'h32;
    localparam csr_num_t CSR_SAVE3  = 14'h33;
    localparam csr_num_t CSR_TID    = 14'h40;
    localparam csr_num_t CSR_TCFG   = 14'h41;
    localparam csr_num_t CSR_TVAL   = 14'h42;
    localparam csr_num_t CSR_TICLR  = 14'h44;

    ////////////////////
    // field positions
    ////////////////////
    // plv, datf and datm in crmd are 2 bits wide
    localparam int CRMD_PLV    = 0;
    localparam int CRMD_IE     = 2;
    localparam int CRMD_DA     = 3;
    localparam int CRMD_PG     = 4;
    localparam int CRMD_DATF   = 5;
    localparam int CRMD_DATM   = 7;
    localparam int PRMD_PPLV   = 0;
    localparam int PRMD_PIE    = 2;
    localparam int ECFG_LIE_W  = 13;
    // lie bit 10 is reserved
    localparam logic [12:0] ECFG_LIE_MASK = 13'h1bff;
    localparam int ESTAT_IS_SW = 0;
    localparam int ESTAT_IS_TI = 11;
    localparam int EENTRY_VA   = 6;
    localparam int TCFG_EN     = 0;
    localparam int TCFG_PERIOD = 1;
    localparam int TCFG_INITV  = 2;
    localparam int TICLR_CLR   = 0;

    // exception codes with a bad address
    localparam ecode_t    ECODE_ADE     = 6'h8;
    localparam ecode_t    ECODE_ALE     = 6'h9;
    localparam esubcode_t ESUBCODE_ADEF = 9'h0;

    typedef struct packed {
        logic     we;
        csr_num_t num;
        word_t    wmask;
        word_t    wvalue;
    } csr_wr_t;

    typedef struct packed {
        logic      ex;
        ecode_t    ecode;
        esubcode_t esubcode;
        word_t     pc;
        word_t     vaddr;
    } exc_t;

    // new bits where the mask is set, old bits elsewhere
    function automatic word_t wmerge(word_t old, word_t wmask, word_t wvalue);
        return (wmask & wvalue) | (~wmask & old);
    endfunction

endpackage

// File: hdl/csr_except.sv
`timescale 1ns/1ps

module csr_except (
    input  logic                clk,
    input  logic                rst,
    input  csr_pkg::csr_wr_t    wr,
    input  csr_pkg::exc_t       exc,
    input  logic                ertn,
    output csr_pkg::word_t      crmd_rvalue,
    output csr_pkg::word_t      prmd_rvalue,
    output csr_pkg::word_t      era_rvalue,
    output csr_pkg::word_t      badv_rvalue,
    output csr_pkg::word_t      eentry_rvalue,
    output csr_pkg::ecode_t     estat_ecode,
    output csr_pkg::esubcode_t  estat_esubcode,
    output logic                crmd_ie
);
    import csr_pkg::*;

    plv_t        crmd_plv;
    logic        crmd_da;
    logic        crmd_pg;
    logic [1:0]  crmd_datf;
    logic [1:0]  crmd_datm;
    plv_t        prmd_pplv;
    logic        prmd_pie;
    word_t       era_pc;
    word_t       badv_vaddr;
    logic [25:0] eentry_va;

    word_t crmd_wdata;
    word_t prmd_wdata;
    word_t era_wdata;
    word_t badv_wdata;
    word_t eentry_wdata;
    logic  addr_err;

    always_comb begin
        crmd_rvalue = '0;
        crmd_rvalue[CRMD_PLV +: 2]  = crmd_plv;
        crmd_rvalue[CRMD_IE]        = crmd_ie;
        crmd_rvalue[CRMD_DA]        = crmd_da;
        crmd_rvalue[CRMD_PG]        = crmd_pg;
        crmd_rvalue[CRMD_DATF +: 2] = crmd_datf;
        crmd_rvalue[CRMD_DATM +: 2] = crmd_datm;
        prmd_rvalue = '0;
        prmd_rvalue[PRMD_PPLV +: 2] = prmd_pplv;
        prmd_rvalue[PRMD_PIE]       = prmd_pie;
    end

    assign era_rvalue    = era_pc;
    assign badv_rvalue   = badv_vaddr;
    assign eentry_rvalue = {eentry_va, 6'b0};

    assign crmd_wdata   = wmerge(crmd_rvalue, wr.wmask, wr.wvalue);
    assign prmd_wdata   = wmerge(prmd_rvalue, wr.wmask, wr.wvalue);
    assign era_wdata    = wmerge(era_rvalue, wr.wmask, wr.wvalue);
    assign badv_wdata   = wmerge(badv_rvalue, wr.wmask, wr.wvalue);
    assign eentry_wdata = wmerge(eentry_rvalue, wr.wmask, wr.wvalue);

    assign addr_err = (exc.ecode == ECODE_ADE) || (exc.ecode == ECODE_ALE);

    // exception first, then ertn, then software write
    always_ff @(posedge clk) begin
        if (rst) begin
            crmd_plv  <= '0;
            crmd_ie   <= 1'b0;
            crmd_da   <= 1'b1;
            crmd_pg   <= 1'b0;
            crmd_datf <= '0;
            crmd_datm <= '0;
        end else if (exc.ex) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (ertn) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (wr.we && wr.num == CSR_CRMD) begin
            crmd_plv  <= crmd_wdata[CRMD_PLV +: 2];
            crmd_ie   <= crmd_wdata[CRMD_IE];
            crmd_da   <= crmd_wdata[CRMD_DA];
            crmd_pg   <= crmd_wdata[CRMD_PG];
            crmd_datf <= crmd_wdata[CRMD_DATF +: 2];
            crmd_datm <= crmd_wdata[CRMD_DATM +: 2];
        end
    end

    ////////////////////
    // saved state on exception entry
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            prmd_pplv      <= '0;
            prmd_pie       <= 1'b0;
            era_pc         <= '0;
            badv_vaddr     <= '0;
            eentry_va      <= '0;
            estat_ecode    <= '0;
            estat_esubcode <= '0;
        end else begin
            if (exc.ex) begin
                prmd_pplv      <= crmd_plv;
                prmd_pie       <= crmd_ie;
                era_pc         <= exc.pc;
                estat_ecode    <= exc.ecode;
                estat_esubcode <= exc.esubcode;
            end else begin
                if (wr.we && wr.num == CSR_PRMD) begin
                    prmd_pplv <= prmd_wdata[PRMD_PPLV +: 2];
                    prmd_pie  <= prmd_wdata[PRMD_PIE];
                end
                if (wr.we && wr.num == CSR_ERA)
                    era_pc <= era_wdata;
            end
            // fetch faults report the pc itself
            if (exc.ex && addr_err) begin
                if (exc.ecode == ECODE_ADE && exc.esubcode == ESUBCODE_ADEF)
                    badv_vaddr <= exc.pc;
                else
                    badv_vaddr <= exc.vaddr;
            end else if (wr.we && wr.num == CSR_BADV) begin
                badv_vaddr <= badv_wdata;
            end
            if (wr.we && wr.num == CSR_EENTRY)
                eentry_va <= eentry_wdata[31:EENTRY_VA];
        end
    end

endmodule

// File: hdl/csr_intr.sv
`timescale 1ns/1ps

module csr_intr (
    input  logic             clk,
    input  logic             rst,
    input  csr_pkg::csr_wr_t wr,
    input  logic             crmd_ie,
    input  logic             timer_is,
    output csr_pkg::word_t   ecfg_rvalue,
    output logic [1:0]       sw_is,
    output logic             has_int
);
    import csr_pkg::*;

    logic [ECFG_LIE_W-1:0] ecfg_lie;
    logic [ECFG_LIE_W-1:0] is_vec;
    word_t                 ecfg_wdata;
    word_t                 estat_wdata;

    assign ecfg_rvalue = {{(32 - ECFG_LIE_W){1'b0}}, ecfg_lie};
    assign ecfg_wdata  = wmerge(ecfg_rvalue, wr.wmask, wr.wvalue);
    // only the software bits of estat are writable
    assign estat_wdata = wmerge({30'b0, sw_is}, wr.wmask, wr.wvalue);

    always_ff @(posedge clk) begin
        if (rst) begin
            ecfg_lie <= '0;
            sw_is    <= '0;
        end else begin
            if (wr.we && wr.num == CSR_ECFG)
                ecfg_lie <= ecfg_wdata[ECFG_LIE_W-1:0] & ECFG_LIE_MASK;
            if (wr.we && wr.num == CSR_ESTAT)
                sw_is <= estat_wdata[ESTAT_IS_SW +: 2];
        end
    end

    // pending bits in estat layout with hardware lines tied off
    always_comb begin
        is_vec = '0;
        is_vec[ESTAT_IS_SW +: 2] = sw_is;
        is_vec[ESTAT_IS_TI]      = timer_is;
    end

    assign has_int = (|(is_vec & ecfg_lie)) && crmd_ie;

endmodule

// File: hdl/csr_timer.sv
`timescale 1ns/1ps

module csr_timer #(
    parameter int unsigned STABLE_CNT_W = 64
) (
    input  logic                    clk,
    input  logic                    rst,
    input  csr_pkg::csr_wr_t        wr,
    output csr_pkg::word_t          tid_rvalue,
    output csr_pkg::word_t          tcfg_rvalue,
    output csr_pkg::word_t          tval_rvalue,
    output logic                    timer_is,
    output logic [STABLE_CNT_W-1:0] count
);
    import csr_pkg::*;

    word_t       tid_q;
    logic        tcfg_en;
    logic        tcfg_period;
    logic [29:0] tcfg_initv;
    word_t       tval;

    word_t tid_wdata;
    word_t tcfg_wdata;
    logic  wr_tcfg;
    logic  ticlr;

    assign tid_rvalue  = tid_q;
    assign tcfg_rvalue = {tcfg_initv, tcfg_period, tcfg_en};
    assign tval_rvalue = tval;

    assign tid_wdata  = wmerge(tid_q, wr.wmask, wr.wvalue);
    assign tcfg_wdata = wmerge(tcfg_rvalue, wr.wmask, wr.wvalue);
    assign wr_tcfg    = wr.we && wr.num == CSR_TCFG;
    assign ticlr      = wr.we && wr.num == CSR_TICLR
                        && wr.wmask[TICLR_CLR] && wr.wvalue[TICLR_CLR];

    always_ff @(posedge clk) begin
        if (rst) begin
            tid_q   <= '0;
            tcfg_en <= 1'b0;
        end else begin
            if (wr.we && wr.num == CSR_TID)
                tid_q <= tid_wdata;
            if (wr_tcfg)
                tcfg_en <= tcfg_wdata[TCFG_EN];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_tcfg) begin
            tcfg_period <= tcfg_wdata[TCFG_PERIOD];
            tcfg_initv  <= tcfg_wdata[31:TCFG_INITV];
        end
    end

    ////////////////////
    // tval down-counter
    ////////////////////
    // one-shot wraps to all ones and parks there
    always_ff @(posedge clk) begin
        if (rst) begin
            tval <= '1;
        end else if (wr_tcfg && tcfg_wdata[TCFG_EN]) begin
            tval <= {tcfg_wdata[31:TCFG_INITV], 2'b0};
        end else if (tcfg_en && tval != '1) begin
            if (tval == '0 && tcfg_period)
                tval <= {tcfg_initv, 2'b0};
            else
                tval <= tval - 1'b1;
        end
    end

    // expiry wins over a same-cycle clear
    always_ff @(posedge clk) begin
        if (rst)
            timer_is <= 1'b0;
        else if (tcfg_en && tval == '0)
            timer_is <= 1'b1;
        else if (ticlr)
            timer_is <= 1'b0;
    end

    // free-running stable counter
    always_ff @(posedge clk) begin
        if (rst)
            count <= '0;
        else
            count <= count + 1'b1;
    end

endmodule

// File: hdl/csr_file.sv
`timescale 1ns/1ps

module csr_file #(
    parameter int unsigned STABLE_CNT_W = 64
) (
    input  logic                    clk,
    input  logic                    rst,
    input  csr_pkg::csr_wr_t        wr,
    input  csr_pkg::csr_num_t       rd_num,
    input  csr_pkg::exc_t           exc,
    input  logic                    ertn,
    output csr_pkg::word_t          rvalue,
    output csr_pkg::word_t          ex_entry,
    output csr_pkg::word_t          ertn_entry,
    output logic                    has_int,
    output csr_pkg::word_t          tid,
    output logic [STABLE_CNT_W-1:0] count
);
    import csr_pkg::*;

    word_t     crmd_rvalue;
    word_t     prmd_rvalue;
    word_t     era_rvalue;
    word_t     badv_rvalue;
    word_t     eentry_rvalue;
    word_t     ecfg_rvalue;
    word_t     estat_rvalue;
    word_t     tid_rvalue;
    word_t     tcfg_rvalue;
    word_t     tval_rvalue;
    ecode_t    estat_ecode;
    esubcode_t estat_esubcode;
    logic      crmd_ie;
    logic      timer_is;
    logic [1:0] sw_is;
    word_t     save_q [4];

    csr_except u_except (
        .clk            (clk),
        .rst            (rst),
        .wr             (wr),
        .exc            (exc),
        .ertn           (ertn),
        .crmd_rvalue    (crmd_rvalue),
        .prmd_rvalue    (prmd_rvalue),
        .era_rvalue     (era_rvalue),
        .badv_rvalue    (badv_rvalue),
        .eentry_rvalue  (eentry_rvalue),
        .estat_ecode    (estat_ecode),
        .estat_esubcode (estat_esubcode),
        .crmd_ie        (crmd_ie)
    );

    csr_intr u_intr (
        .clk         (clk),
        .rst         (rst),
        .wr          (wr),
        .crmd_ie     (crmd_ie),
        .timer_is    (timer_is),
        .ecfg_rvalue (ecfg_rvalue),
        .sw_is       (sw_is),
        .has_int     (has_int)
    );

    csr_timer #(
        .STABLE_CNT_W (STABLE_CNT_W)
    ) u_timer (
        .clk         (clk),
        .rst         (rst),
        .wr          (wr),
        .tid_rvalue  (tid_rvalue),
        .tcfg_rvalue (tcfg_rvalue),
        .tval_rvalue (tval_rvalue),
        .timer_is    (timer_is),
        .count       (count)
    );

    // save0..3 sit on consecutive numbers
    always_ff @(posedge clk) begin
        if (rst) begin
            save_q <= '{default: '0};
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (wr.we && wr.num == CSR_SAVE0 + csr_num_t'(i))
                    save_q[i] <= wmerge(save_q[i], wr.wmask, wr.wvalue);
            end
        end
    end

    // esubcode, ecode and is[12:0] with is[12] and is[10:2] tied low
    assign estat_rvalue = {1'b0, estat_esubcode, estat_ecode, 3'b0,
                           1'b0, timer_is, 9'b0, sw_is};

    ////////////////////
    // read mux
    ////////////////////
    always_comb begin
        case (rd_num)
            CSR_CRMD:   rvalue = crmd_rvalue;
            CSR_PRMD:   rvalue = prmd_rvalue;
            CSR_ECFG:   rvalue = ecfg_rvalue;
            CSR_ESTAT:  rvalue = estat_rvalue;
            CSR_ERA:    rvalue = era_rvalue;
            CSR_BADV:   rvalue = badv_rvalue;
            CSR_EENTRY: rvalue = eentry_rvalue;
            CSR_SAVE0:  rvalue = save_q[0];
            CSR_SAVE1:  rvalue = save_q[1];
            CSR_SAVE2:  rvalue = save_q[2];
            CSR_SAVE3:  rvalue = save_q[3];
            CSR_TID:    rvalue = tid_rvalue;
            CSR_TCFG:   rvalue = tcfg_rvalue;
            CSR_TVAL:   rvalue = tval_rvalue;
            // ticlr always reads back zero
            default:    rvalue = '0;
        endcase
    end

    // entry points for fetch
    assign ex_entry   = eentry_rvalue;
    assign ertn_entry = era_rvalue;
    assign tid        = tid_rvalue;

endmodule

// File: sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int HALF_PERIOD_NS = 50
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

endmodule

// File: sim/csr_file_assert.sv
`timescale 1ns/1ps

module csr_file_assert #(
    parameter int unsigned STABLE_CNT_W = 64
) (
    input logic                    clk,
    input logic                    rst,
    input logic                    exc_ex,
    input logic                    ertn,
    input logic                    crmd_ie,
    input logic                    has_int,
    input logic [STABLE_CNT_W-1:0] count
);

    int fail_count = 0;

    // interrupts are gated by the global enable
    int_needs_ie: assert property (@(posedge clk) disable iff (rst) has_int |-> crmd_ie)
        else begin
            fail_count++;
            $error("has_int high while CRMD.IE is clear");
        end

    // exception entry and return never share a cycle
    ex_ertn_apart: assert property (@(posedge clk) disable iff (rst) !(exc_ex && ertn))
        else begin
            fail_count++;
            $error("exception and ertn pulsed in the same cycle");
        end

    // first edge out of reset has no valid previous count
    count_steps: assert property (@(posedge clk) disable iff (rst)
                                  !$past(rst) |-> count == $past(count) + 1'b1)
        else begin
            fail_count++;
            $error("stable counter did not advance by one");
        end

endmodule

bind csr_file csr_file_assert #(
    .STABLE_CNT_W (STABLE_CNT_W)
) u_assert (
    .clk     (clk),
    .rst     (rst),
    .exc_ex  (exc.ex),
    .ertn    (ertn),
    .crmd_ie (crmd_ie),
    .has_int (has_int),
    .count   (count)
);

// File: sim/csr_file_tb.sv
`timescale 1ns/1ps

module csr_file_tb;
    import csr_pkg::*;

    localparam int unsigned CNT_W       = 64;
    localparam int          TIMEOUT     = 200;
    localparam int          COUNT_GAP   = 17;
    localparam int          ECODE_LSB   = 16;
    localparam int          ESUBCODE_LSB = 22;

    logic             clk;
    logic             rst;
    csr_wr_t          wr;
    csr_num_t         rd_num;
    exc_t             exc;
    logic             ertn;
    word_t            rvalue;
    word_t            ex_entry;
    word_t            ertn_entry;
    logic             has_int;
    word_t            tid;
    logic [CNT_W-1:0] count;

    int    errors;
    int    checks;
    word_t eentry_exp;

    tb_clock u_clock (
        .clk (clk)
    );

    csr_file #(
        .STABLE_CNT_W (CNT_W)
    ) dut (
        .clk        (clk),
        .rst        (rst),
        .wr         (wr),
        .rd_num     (rd_num),
        .exc        (exc),
        .ertn       (ertn),
        .rvalue     (rvalue),
        .ex_entry   (ex_entry),
        .ertn_entry (ertn_entry),
        .has_int    (has_int),
        .tid        (tid),
        .count      (count)
    );

    ////////////////////
    // helpers
    ////////////////////
    // step past the next rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic compare_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic read_csr(input csr_num_t num, output word_t value);
        rd_num = num;
        #1;
        value = rvalue;
    endtask

    task automatic check_csr(input csr_num_t num, input string name, input word_t exp);
        word_t value;
        read_csr(num, value);
        compare_word(name, value, exp);
    endtask

    task automatic check_has_int(input logic exp);
        #1;
        compare_word("has_int", word_t'(has_int), word_t'(exp));
    endtask

    task automatic check_timer_bit(input logic exp);
        word_t estat;
        read_csr(CSR_ESTAT, estat);
        compare_word("ESTAT.IS[11]", word_t'(estat[ESTAT_IS_TI]), word_t'(exp));
    endtask

    task automatic write_csr(input csr_num_t num, input word_t wmask, input word_t wvalue);
        wr.we     = 1'b1;
        wr.num    = num;
        wr.wmask  = wmask;
        wr.wvalue = wvalue;
        next_cycle();
        wr.we = 1'b0;
    endtask

    task automatic raise_exception(input ecode_t ecode, input esubcode_t esubcode,
                                   input word_t pc, input word_t vaddr);
        exc.ex       = 1'b1;
        exc.ecode    = ecode;
        exc.esubcode = esubcode;
        exc.pc       = pc;
        exc.vaddr    = vaddr;
        next_cycle();
        exc.ex = 1'b0;
    endtask

    task automatic pulse_ertn();
        ertn = 1'b1;
        next_cycle();
        ertn = 1'b0;
    endtask

    task automatic wait_timer_is(input string what);
        word_t estat;
        int    n;
        n = 0;
        read_csr(CSR_ESTAT, estat);
        while (!estat[ESTAT_IS_TI] && n < TIMEOUT) begin
            next_cycle();
            read_csr(CSR_ESTAT, estat);
            n++;
        end
        checks++;
        if (!estat[ESTAT_IS_TI]) begin
            errors++;
            $display("Error at %0t ns: %s timer interrupt not seen within %0d cycles",
                     $time, what, TIMEOUT);
        end
    endtask

    ////////////////////
    // directed tests
    ////////////////////
    task automatic test_reset_and_masked_writes();
        csr_num_t nums [6];
        string    names [6];
        word_t    model [6];
        word_t    value;
        word_t    wmask;
        word_t    wvalue;
        word_t    exp;
        nums  = '{CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_ERA, CSR_EENTRY};
        names = '{"SAVE0", "SAVE1", "SAVE2", "SAVE3", "ERA", "EENTRY"};
        model = '{default: '0};
        check_csr(CSR_CRMD, "CRMD", 32'h1 << CRMD_DA);
        check_csr(CSR_ECFG, "ECFG", '0);
        read_csr(CSR_TCFG, value);
        compare_word("TCFG.EN", word_t'(value[TCFG_EN]), '0);
        check_csr(CSR_ESTAT, "ESTAT", '0);
        check_csr(CSR_TVAL, "TVAL", '1);
        check_csr(CSR_TICLR, "TICLR", '0);
        check_csr(14'h3ff, "unmapped CSR", '0);
        // second round merges into non-zero old contents
        for (int r = 0; r < 2; r++) begin
            for (int i = 0; i < 6; i++) begin
                wmask  = (r == 0) ? 32'hffff_ffff : $urandom;
                wvalue = $urandom;
                exp    = (wvalue & wmask) | (model[i] & ~wmask);
                if (nums[i] == CSR_EENTRY)
                    exp[5:0] = '0;
                write_csr(nums[i], wmask, wvalue);
                check_csr(nums[i], names[i], exp);
                model[i] = exp;
            end
        end
        eentry_exp = model[5];
    endtask

    task automatic test_exception_entry_return();
        word_t     pc;
        word_t     vaddr;
        esubcode_t esub;
        write_csr(CSR_CRMD, 32'h7, 32'h7);
        check_csr(CSR_CRMD, "CRMD", 32'hf);
        pc    = $urandom & ~32'h3;
        vaddr = $urandom;
        esub  = esubcode_t'($urandom) | 9'h1;
        raise_exception(ECODE_ALE, esub, pc, vaddr);
        check_csr(CSR_PRMD, "PRMD", 32'h7);
        check_csr(CSR_CRMD, "CRMD", 32'h8);
        check_csr(CSR_ERA, "ERA", pc);
        compare_word("ertn_entry", ertn_entry, pc);
        compare_word("ex_entry", ex_entry, eentry_exp);
        check_csr(CSR_BADV, "BADV", vaddr);
        check_csr(CSR_ESTAT, "ESTAT", (word_t'(esub) << ESUBCODE_LSB)
                                      | (word_t'(ECODE_ALE) << ECODE_LSB));
        // fetch fault taken from plv 3
        write_csr(CSR_CRMD, 32'h7, 32'h7);
        pc    = $urandom & ~32'h3;
        vaddr = $urandom;
        raise_exception(ECODE_ADE, ESUBCODE_ADEF, pc, vaddr);
        check_csr(CSR_BADV, "BADV", pc);
        check_csr(CSR_ESTAT, "ESTAT", (word_t'(ESUBCODE_ADEF) << ESUBCODE_LSB)
                                      | (word_t'(ECODE_ADE) << ECODE_LSB));
        check_csr(CSR_PRMD, "PRMD", 32'h7);
        pulse_ertn();
        check_csr(CSR_CRMD, "CRMD", 32'hf);
        compare_word("ertn_entry", ertn_entry, pc);
    endtask

    task automatic test_soft_interrupts();
        word_t value;
        write_csr(CSR_ECFG, '1, '1);
        check_csr(CSR_ECFG, "ECFG", 32'h1bff);
        check_has_int(1'b0);
        write_csr(CSR_ESTAT, 32'h1, 32'h1);
        read_csr(CSR_ESTAT, value);
        compare_word("ESTAT.IS[1:0]", value & 32'h3, 32'h1);
        check_has_int(1'b1);
        write_csr(CSR_CRMD, 32'h4, 32'h0);
        check_has_int(1'b0);
        write_csr(CSR_CRMD, 32'h4, 32'h4);
        check_has_int(1'b1);
        write_csr(CSR_ECFG, 32'h1, 32'h0);
        check_has_int(1'b0);
        write_csr(CSR_ESTAT, 32'h2, 32'h2);
        check_has_int(1'b1);
        write_csr(CSR_ECFG, 32'h2, 32'h0);
        check_has_int(1'b0);
        write_csr(CSR_ESTAT, 32'h3, 32'h0);
        check_csr(CSR_ECFG, "ECFG", 32'h1bfc);
    endtask

    task automatic test_oneshot_timer();
        write_csr(CSR_TCFG, '1, (32'd3 << TCFG_INITV) | 32'h1);
        check_csr(CSR_TVAL, "TVAL", 32'd12);
        repeat (3) next_cycle();
        check_csr(CSR_TVAL, "TVAL", 32'd9);
        wait_timer_is("one-shot");
        check_csr(CSR_TVAL, "TVAL", '1);
        check_has_int(1'b1);
        repeat (3) next_cycle();
        check_csr(CSR_TVAL, "TVAL", '1);
        write_csr(CSR_ECFG, 32'h800, 32'h0);
        check_has_int(1'b0);
        write_csr(CSR_ECFG, 32'h800, 32'h800);
        check_has_int(1'b1);
        write_csr(CSR_TICLR, 32'h1, 32'h1);
        check_timer_bit(1'b0);
        check_has_int(1'b0);
    endtask

    task automatic test_periodic_timer();
        word_t estat;
        word_t tval;
        logic  saw_ones;
        int    n;
        write_csr(CSR_TCFG, '1, (32'd2 << TCFG_INITV) | 32'h3);
        wait_timer_is("first periodic");
        write_csr(CSR_TICLR, 32'h1, 32'h1);
        check_timer_bit(1'b0);
        n        = 0;
        saw_ones = 1'b0;
        read_csr(CSR_ESTAT, estat);
        while (!estat[ESTAT_IS_TI] && n < TIMEOUT) begin
            read_csr(CSR_TVAL, tval);
            if (tval == '1)
                saw_ones = 1'b1;
            next_cycle();
            read_csr(CSR_ESTAT, estat);
            n++;
        end
        checks += 2;
        if (!estat[ESTAT_IS_TI]) begin
            errors++;
            $display("Error at %0t ns: second periodic expiry not seen within %0d cycles",
                     $time, TIMEOUT);
        end
        if (saw_ones) begin
            errors++;
            $display("Error at %0t ns: TVAL read all ones in periodic mode", $time);
        end
        // stop the timer and drop its pending bit
        write_csr(CSR_TCFG, '1, '0);
        write_csr(CSR_TICLR, 32'h1, 32'h1);
        check_timer_bit(1'b0);
    endtask

    task automatic test_count_and_tid();
        logic [CNT_W-1:0] c0;
        logic [CNT_W-1:0] c1;
        word_t            first;
        word_t            wmask;
        word_t            wvalue;
        word_t            exp;
        c0 = count;
        repeat (COUNT_GAP) next_cycle();
        c1 = count;
        checks++;
        if (c1 - c0 !== CNT_W'(COUNT_GAP)) begin
            errors++;
            $display("Error at %0t ns: count step is %0d, expected %0d",
                     $time, c1 - c0, COUNT_GAP);
        end
        first = $urandom;
        write_csr(CSR_TID, '1, first);
        compare_word("tid", tid, first);
        wmask  = $urandom;
        wvalue = $urandom;
        exp    = (wvalue & wmask) | (first & ~wmask);
        write_csr(CSR_TID, wmask, wvalue);
        compare_word("tid", tid, exp);
        check_csr(CSR_TID, "TID", exp);
    endtask

    initial begin
        int assert_fails;
        errors = 0;
        checks = 0;
        rst    = 1'b1;
        wr     = '0;
        rd_num = '0;
        exc    = '0;
        ertn   = 1'b0;
        void'($urandom(32'h44e1));
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        test_reset_and_masked_writes();
        test_exception_entry_return();
        test_soft_interrupts();
        test_oneshot_timer();
        test_periodic_timer();
        test_count_and_tid();

        assert_fails = dut.u_assert.fail_count;
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: list.f
hdl/csr_pkg.sv
hdl/csr_except.sv
hdl/csr_intr.sv
hdl/csr_timer.sv
hdl/csr_file.sv
sim/tb_clock.sv
sim/csr_file_assert.sv
sim/csr_file_tb.sv

// File: Bender.yml
package:
  name: csr_file

sources:
  - files:
      - hdl/csr_pkg.sv
      - hdl/csr_except.sv
      - hdl/csr_intr.sv
      - hdl/csr_timer.sv
      - hdl/csr_file.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/csr_file_assert.sv
      - sim/csr_file_tb.sv
